// File: cache_geometry_pkg.sv
package cache_geometry_pkg;

	// addresses count words, not bytes
	localparam int ADDR_BITS = 32;
	localparam int DATA_BITS = 32;

	localparam int NUM_LINES = 4;
	localparam int LINE_IDX_BITS = 2;

	// one line holds an aligned region of LINE_WORDS words
	localparam int LINE_WORDS = 4;
	localparam int OFFSET_BITS = 2;

	// the tag is the region number, the word address without its offset
	localparam int TAG_BITS = ADDR_BITS - OFFSET_BITS;

	// saturating use counter per line, the lowest count is evicted first
	localparam int HIT_CNT_BITS = 4;

endpackage

// File: cache_ctrl_pkg.sv
package cache_ctrl_pkg;

	// who issued the request that is in service
	localparam int SRC_BITS = 2;
	localparam logic [SRC_BITS-1:0] SRC_DCACHE_RD = 2'd0;
	localparam logic [SRC_BITS-1:0] SRC_DCACHE_WR = 2'd1;
	localparam logic [SRC_BITS-1:0] SRC_ICACHE_RD = 2'd2;

	localparam int QUEUE_PTR_BITS = 2;
	// one bit wider than a pointer so it also serves as the full level of the count
	localparam logic [QUEUE_PTR_BITS:0] QUEUE_DEPTH = 3'd4;

	// miss controller states
	localparam int STATE_BITS = 3;
	localparam logic [STATE_BITS-1:0] ST_LOOKUP = 3'd0;
	localparam logic [STATE_BITS-1:0] ST_HIT = 3'd1;
	localparam logic [STATE_BITS-1:0] ST_VICTIM = 3'd2;
	localparam logic [STATE_BITS-1:0] ST_WRITE_BACK = 3'd3;
	localparam logic [STATE_BITS-1:0] ST_FILL_REQ = 3'd4;
	localparam logic [STATE_BITS-1:0] ST_FILL_WAIT = 3'd5;

endpackage

// File: request_queue.sv
`timescale 1ns/10ps

module request_queue #(
	parameter int WIDTH = cache_geometry_pkg::ADDR_BITS
) (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             push,
	input  logic             pop,
	input  logic [WIDTH-1:0] entry_in,
	output logic [WIDTH-1:0] entry_out,
	output logic             not_empty,
	output logic             not_full
);

	logic [WIDTH-1:0] store [cache_ctrl_pkg::QUEUE_DEPTH];
	logic [cache_ctrl_pkg::QUEUE_PTR_BITS-1:0] wr_ptr;
	logic [cache_ctrl_pkg::QUEUE_PTR_BITS-1:0] rd_ptr;
	logic [cache_ctrl_pkg::QUEUE_PTR_BITS:0] count;

	assign entry_out = store[rd_ptr];
	assign not_empty = (count != '0);
	assign not_full = (count != cache_ctrl_pkg::QUEUE_DEPTH);

	// pointers wrap by themselves since the depth is a power of two
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			store[wr_ptr] <= entry_in;
	end

	assert property (@(posedge clk) disable iff (!reset_n) push |-> not_full);
	assert property (@(posedge clk) disable iff (!reset_n) pop |-> not_empty);

endmodule

// File: request_intake.sv
`timescale 1ns/10ps

module request_intake (
	input  logic                                     clk,
	input  logic                                     reset_n,
	input  logic [cache_geometry_pkg::ADDR_BITS-1:0] dcache_rdaddr,
	input  logic                                     dcache_rdreq,
	output logic                                     dcache_rd_ready,
	input  logic [cache_geometry_pkg::ADDR_BITS-1:0] dcache_wraddr,
	input  logic [cache_geometry_pkg::DATA_BITS-1:0] dcache_in,
	input  logic                                     dcache_wrreq,
	output logic                                     dcache_wr_ready,
	input  logic [cache_geometry_pkg::ADDR_BITS-1:0] icache_rdaddr,
	input  logic                                     icache_rdreq,
	output logic                                     icache_rd_ready,
	input  logic                                     req_done,
	output logic                                     req_valid,
	output logic [cache_geometry_pkg::ADDR_BITS-1:0] req_addr,
	output logic [cache_geometry_pkg::DATA_BITS-1:0] req_data,
	output logic [cache_ctrl_pkg::SRC_BITS-1:0]      req_source
);

	logic [cache_geometry_pkg::ADDR_BITS-1:0] drd_addr;
	logic [cache_geometry_pkg::ADDR_BITS-1:0] ird_addr;
	logic [cache_geometry_pkg::ADDR_BITS+cache_geometry_pkg::DATA_BITS-1:0] wr_entry;
	logic drd_ne;
	logic dwr_ne;
	logic ird_ne;
	logic locked;
	logic [cache_ctrl_pkg::SRC_BITS-1:0] locked_src;
	logic [cache_ctrl_pkg::SRC_BITS-1:0] pick_src;

	request_queue #(.WIDTH(cache_geometry_pkg::ADDR_BITS)) dcache_rd_q (
		.clk(clk), .reset_n(reset_n),
		.push(dcache_rdreq & dcache_rd_ready),
		.pop(req_done && req_source == cache_ctrl_pkg::SRC_DCACHE_RD),
		.entry_in(dcache_rdaddr), .entry_out(drd_addr),
		.not_empty(drd_ne), .not_full(dcache_rd_ready)
	);

	request_queue #(
		.WIDTH(cache_geometry_pkg::ADDR_BITS + cache_geometry_pkg::DATA_BITS)
	) dcache_wr_q (
		.clk(clk), .reset_n(reset_n),
		.push(dcache_wrreq & dcache_wr_ready),
		.pop(req_done && req_source == cache_ctrl_pkg::SRC_DCACHE_WR),
		.entry_in({dcache_wraddr, dcache_in}), .entry_out(wr_entry),
		.not_empty(dwr_ne), .not_full(dcache_wr_ready)
	);

	request_queue #(.WIDTH(cache_geometry_pkg::ADDR_BITS)) icache_rd_q (
		.clk(clk), .reset_n(reset_n),
		.push(icache_rdreq & icache_rd_ready),
		.pop(req_done && req_source == cache_ctrl_pkg::SRC_ICACHE_RD),
		.entry_in(icache_rdaddr), .entry_out(ird_addr),
		.not_empty(ird_ne), .not_full(icache_rd_ready)
	);

	// data read first, then data write, then instruction read
	always_comb begin
		if (drd_ne)
			pick_src = cache_ctrl_pkg::SRC_DCACHE_RD;
		else if (dwr_ne)
			pick_src = cache_ctrl_pkg::SRC_DCACHE_WR;
		else
			pick_src = cache_ctrl_pkg::SRC_ICACHE_RD;
	end

	// once the controller has seen a request the choice stays until it is done
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			locked <= 1'b0;
			locked_src <= cache_ctrl_pkg::SRC_DCACHE_RD;
		end else if (req_done) begin
			locked <= 1'b0;
		end else if (req_valid && !locked) begin
			locked <= 1'b1;
			locked_src <= pick_src;
		end
	end

	assign req_valid = locked | drd_ne | dwr_ne | ird_ne;
	assign req_source = locked ? locked_src : pick_src;
	assign req_data = wr_entry[cache_geometry_pkg::DATA_BITS-1:0];

	always_comb begin
		case (req_source)
			cache_ctrl_pkg::SRC_DCACHE_RD: req_addr = drd_addr;
			cache_ctrl_pkg::SRC_DCACHE_WR:
				req_addr = wr_entry[cache_geometry_pkg::ADDR_BITS+cache_geometry_pkg::DATA_BITS-1:
					cache_geometry_pkg::DATA_BITS];
			default: req_addr = ird_addr;
		endcase
	end

endmodule

// File: cache_lines.sv
`timescale 1ns/10ps

module cache_lines (
	input  logic                                       clk,
	input  logic                                       reset_n,
	input  logic [cache_geometry_pkg::ADDR_BITS-1:0]   lookup_addr,
	input  logic                                       access_en,
	input  logic                                       write_en,
	input  logic [cache_geometry_pkg::DATA_BITS-1:0]   write_data,
	input  logic                                       claim_victim,
	input  logic [cache_geometry_pkg::OFFSET_BITS-1:0] word_sel,
	input  logic                                       fill_en,
	input  logic [cache_geometry_pkg::DATA_BITS-1:0]   fill_data,
	output logic                                       hit,
	output logic [cache_geometry_pkg::DATA_BITS-1:0]   read_data,
	output logic                                       victim_dirty,
	output logic [cache_geometry_pkg::TAG_BITS-1:0]    victim_tag,
	output logic [cache_geometry_pkg::DATA_BITS-1:0]   flush_data
);

	logic [cache_geometry_pkg::TAG_BITS-1:0] tags [cache_geometry_pkg::NUM_LINES];
	logic [cache_geometry_pkg::DATA_BITS-1:0]
		data [cache_geometry_pkg::NUM_LINES][cache_geometry_pkg::LINE_WORDS];
	logic [cache_geometry_pkg::HIT_CNT_BITS-1:0] hit_cnt [cache_geometry_pkg::NUM_LINES];
	logic [cache_geometry_pkg::NUM_LINES-1:0] valid;
	logic [cache_geometry_pkg::NUM_LINES-1:0] dirty;
	logic [cache_geometry_pkg::NUM_LINES-1:0] hit_vec;
	logic [cache_geometry_pkg::LINE_IDX_BITS-1:0] hit_idx;
	logic [cache_geometry_pkg::LINE_IDX_BITS-1:0] best_idx;
	logic [cache_geometry_pkg::LINE_IDX_BITS-1:0] victim_idx;
	logic [cache_geometry_pkg::TAG_BITS-1:0] lookup_tag;
	logic [cache_geometry_pkg::OFFSET_BITS-1:0] lookup_off;
	logic fill_last;

	assign lookup_tag = lookup_addr[cache_geometry_pkg::ADDR_BITS-1:cache_geometry_pkg::OFFSET_BITS];
	assign lookup_off = lookup_addr[cache_geometry_pkg::OFFSET_BITS-1:0];
	assign fill_last = fill_en && (&word_sel);

	always_comb begin
		hit_idx = '0;
		for (int i = 0; i < cache_geometry_pkg::NUM_LINES; i++) begin
			hit_vec[i] = valid[i] && (tags[i] == lookup_tag);
			if (hit_vec[i])
				hit_idx = i[cache_geometry_pkg::LINE_IDX_BITS-1:0];
		end
	end

	// strict compare keeps the lowest index on a tie
	always_comb begin
		best_idx = '0;
		for (int i = 1; i < cache_geometry_pkg::NUM_LINES; i++) begin
			if (hit_cnt[i] < hit_cnt[best_idx])
				best_idx = i[cache_geometry_pkg::LINE_IDX_BITS-1:0];
		end
	end

	assign hit = |hit_vec;
	assign read_data = data[hit_idx][lookup_off];
	assign victim_dirty = dirty[victim_idx];
	assign victim_tag = tags[victim_idx];
	assign flush_data = data[victim_idx][word_sel];

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			valid <= '0;
			dirty <= '0;
			victim_idx <= '0;
			for (int i = 0; i < cache_geometry_pkg::NUM_LINES; i++)
				hit_cnt[i] <= '0;
		end else begin
			if (access_en && hit) begin
				if (hit_cnt[hit_idx] != '1)
					hit_cnt[hit_idx] <= hit_cnt[hit_idx] + 1'b1;
				if (write_en)
					dirty[hit_idx] <= 1'b1;
			end
			if (claim_victim)
				victim_idx <= best_idx;
			// the victim stays invalid while its words are being replaced
			if (fill_en) begin
				valid[victim_idx] <= fill_last;
				dirty[victim_idx] <= 1'b0;
				hit_cnt[victim_idx] <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access_en && write_en && hit)
			data[hit_idx][lookup_off] <= write_data;
		if (fill_en)
			data[victim_idx][word_sel] <= fill_data;
		if (fill_last)
			tags[victim_idx] <= lookup_tag;
	end

	assert property (@(posedge clk) disable iff (!reset_n) $onehot0(hit_vec));

endmodule

// File: miss_controller.sv
`timescale 1ns/10ps

module miss_controller (
	input  logic                                       clk,
	input  logic                                       reset_n,
	input  logic                                       req_valid,
	input  logic [cache_geometry_pkg::ADDR_BITS-1:0]   req_addr,
	input  logic [cache_ctrl_pkg::SRC_BITS-1:0]        req_source,
	input  logic                                       hit,
	input  logic                                       victim_dirty,
	input  logic [cache_geometry_pkg::TAG_BITS-1:0]    victim_tag,
	input  logic [cache_geometry_pkg::DATA_BITS-1:0]   flush_data,
	input  logic                                       mem_out_valid,
	output logic                                       req_done,
	output logic                                       resp_valid,
	output logic                                       access_en,
	output logic                                       write_en,
	output logic                                       claim_victim,
	output logic [cache_geometry_pkg::OFFSET_BITS-1:0] word_sel,
	output logic                                       fill_en,
	output logic [cache_geometry_pkg::ADDR_BITS-1:0]   mem_addr,
	output logic [cache_geometry_pkg::DATA_BITS-1:0]   mem_in,
	output logic                                       mem_wrreq,
	output logic                                       mem_rdreq
);

	logic [cache_ctrl_pkg::STATE_BITS-1:0] state;
	logic [cache_geometry_pkg::OFFSET_BITS-1:0] word_cnt;
	logic is_write;

	assign is_write = (req_source == cache_ctrl_pkg::SRC_DCACHE_WR);

	// a hit is served in the cycle after lookup, while the queue head is still in place
	assign access_en = (state == cache_ctrl_pkg::ST_HIT);
	assign write_en = access_en && is_write;
	assign resp_valid = access_en && !is_write;
	assign req_done = access_en;

	assign claim_victim = (state == cache_ctrl_pkg::ST_LOOKUP) && req_valid && !hit;
	assign fill_en = (state == cache_ctrl_pkg::ST_FILL_WAIT) && mem_out_valid;
	assign mem_wrreq = (state == cache_ctrl_pkg::ST_WRITE_BACK);
	assign mem_rdreq = (state == cache_ctrl_pkg::ST_FILL_REQ);
	assign word_sel = word_cnt;
	assign mem_in = flush_data;

	always_comb begin
		if (state == cache_ctrl_pkg::ST_WRITE_BACK)
			mem_addr = {victim_tag, word_cnt};
		else
			mem_addr = {req_addr[cache_geometry_pkg::ADDR_BITS-1:cache_geometry_pkg::OFFSET_BITS],
				word_cnt};
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= cache_ctrl_pkg::ST_LOOKUP;
			word_cnt <= '0;
		end else begin
			case (state)
				cache_ctrl_pkg::ST_LOOKUP: begin
					if (req_valid && hit)
						state <= cache_ctrl_pkg::ST_HIT;
					else if (req_valid)
						state <= cache_ctrl_pkg::ST_VICTIM;
				end
				cache_ctrl_pkg::ST_HIT:
					state <= cache_ctrl_pkg::ST_LOOKUP;
				// the victim was latched at the end of lookup
				cache_ctrl_pkg::ST_VICTIM: begin
					word_cnt <= '0;
					if (victim_dirty)
						state <= cache_ctrl_pkg::ST_WRITE_BACK;
					else
						state <= cache_ctrl_pkg::ST_FILL_REQ;
				end
				cache_ctrl_pkg::ST_WRITE_BACK: begin
					word_cnt <= word_cnt + 1'b1;
					if (&word_cnt)
						state <= cache_ctrl_pkg::ST_FILL_REQ;
				end
				cache_ctrl_pkg::ST_FILL_REQ:
					state <= cache_ctrl_pkg::ST_FILL_WAIT;
				cache_ctrl_pkg::ST_FILL_WAIT: begin
					if (mem_out_valid) begin
						word_cnt <= word_cnt + 1'b1;
						// after the last word the request is looked up again and hits
						if (&word_cnt)
							state <= cache_ctrl_pkg::ST_LOOKUP;
						else
							state <= cache_ctrl_pkg::ST_FILL_REQ;
					end
				end
				default: state <= cache_ctrl_pkg::ST_LOOKUP;
			endcase
		end
	end

	// memory data may only come back for the one read that is outstanding
	assert property (@(posedge clk) disable iff (!reset_n)
		mem_out_valid |-> (state == cache_ctrl_pkg::ST_FILL_WAIT));

endmodule

// File: response_router.sv
`timescale 1ns/10ps

module response_router (
	input  logic                                     clk,
	input  logic                                     reset_n,
	input  logic                                     resp_valid,
	input  logic [cache_ctrl_pkg::SRC_BITS-1:0]      req_source,
	input  logic [cache_geometry_pkg::DATA_BITS-1:0] read_data,
	output logic [cache_geometry_pkg::DATA_BITS-1:0] dcache_out,
	output logic                                     dcache_out_valid,
	output logic [cache_geometry_pkg::DATA_BITS-1:0] icache_out,
	output logic                                     icache_out_valid
);

	logic to_icache;

	assign to_icache = (req_source == cache_ctrl_pkg::SRC_ICACHE_RD);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			dcache_out_valid <= 1'b0;
			icache_out_valid <= 1'b0;
		end else begin
			dcache_out_valid <= resp_valid && !to_icache;
			icache_out_valid <= resp_valid && to_icache;
		end
	end

	// the data words only change when a response is routed to them
	always_ff @(posedge clk) begin
		if (resp_valid && to_icache)
			icache_out <= read_data;
		if (resp_valid && !to_icache)
			dcache_out <= read_data;
	end

endmodule

// File: hybrid_cache.sv
`timescale 1ns/10ps

module hybrid_cache (
	input  logic                                     clk,
	input  logic                                     reset_n,
	input  logic [cache_geometry_pkg::ADDR_BITS-1:0] dcache_rdaddr,
	input  logic                                     dcache_rdreq,
	output logic                                     dcache_rd_ready,
	output logic [cache_geometry_pkg::DATA_BITS-1:0] dcache_out,
	output logic                                     dcache_out_valid,
	input  logic [cache_geometry_pkg::ADDR_BITS-1:0] dcache_wraddr,
	input  logic [cache_geometry_pkg::DATA_BITS-1:0] dcache_in,
	input  logic                                     dcache_wrreq,
	output logic                                     dcache_wr_ready,
	input  logic [cache_geometry_pkg::ADDR_BITS-1:0] icache_rdaddr,
	input  logic                                     icache_rdreq,
	output logic                                     icache_rd_ready,
	output logic [cache_geometry_pkg::DATA_BITS-1:0] icache_out,
	output logic                                     icache_out_valid,
	output logic [cache_geometry_pkg::ADDR_BITS-1:0] mem_addr,
	output logic [cache_geometry_pkg::DATA_BITS-1:0] mem_in,
	input  logic [cache_geometry_pkg::DATA_BITS-1:0] mem_out,
	input  logic                                     mem_out_valid,
	output logic                                     mem_wrreq,
	output logic                                     mem_rdreq
);

	logic req_valid;
	logic req_done;
	logic [cache_geometry_pkg::ADDR_BITS-1:0] req_addr;
	logic [cache_geometry_pkg::DATA_BITS-1:0] req_data;
	logic [cache_ctrl_pkg::SRC_BITS-1:0] req_source;
	logic resp_valid;
	logic access_en;
	logic write_en;
	logic claim_victim;
	logic fill_en;
	logic [cache_geometry_pkg::OFFSET_BITS-1:0] word_sel;
	logic hit;
	logic victim_dirty;
	logic [cache_geometry_pkg::TAG_BITS-1:0] victim_tag;
	logic [cache_geometry_pkg::DATA_BITS-1:0] flush_data;
	logic [cache_geometry_pkg::DATA_BITS-1:0] read_data;

	request_intake intake_i (
		.clk(clk), .reset_n(reset_n),
		.dcache_rdaddr(dcache_rdaddr), .dcache_rdreq(dcache_rdreq),
		.dcache_rd_ready(dcache_rd_ready),
		.dcache_wraddr(dcache_wraddr), .dcache_in(dcache_in), .dcache_wrreq(dcache_wrreq),
		.dcache_wr_ready(dcache_wr_ready),
		.icache_rdaddr(icache_rdaddr), .icache_rdreq(icache_rdreq),
		.icache_rd_ready(icache_rd_ready),
		.req_done(req_done), .req_valid(req_valid), .req_addr(req_addr),
		.req_data(req_data), .req_source(req_source)
	);

	cache_lines lines_i (
		.clk(clk), .reset_n(reset_n),
		.lookup_addr(req_addr), .access_en(access_en), .write_en(write_en),
		.write_data(req_data), .claim_victim(claim_victim), .word_sel(word_sel),
		.fill_en(fill_en), .fill_data(mem_out),
		.hit(hit), .read_data(read_data), .victim_dirty(victim_dirty),
		.victim_tag(victim_tag), .flush_data(flush_data)
	);

	miss_controller ctrl_i (
		.clk(clk), .reset_n(reset_n),
		.req_valid(req_valid), .req_addr(req_addr), .req_source(req_source),
		.hit(hit), .victim_dirty(victim_dirty), .victim_tag(victim_tag),
		.flush_data(flush_data), .mem_out_valid(mem_out_valid),
		.req_done(req_done), .resp_valid(resp_valid), .access_en(access_en),
		.write_en(write_en), .claim_victim(claim_victim), .word_sel(word_sel),
		.fill_en(fill_en), .mem_addr(mem_addr), .mem_in(mem_in),
		.mem_wrreq(mem_wrreq), .mem_rdreq(mem_rdreq)
	);

	response_router router_i (
		.clk(clk), .reset_n(reset_n),
		.resp_valid(resp_valid), .req_source(req_source), .read_data(read_data),
		.dcache_out(dcache_out), .dcache_out_valid(dcache_out_valid),
		.icache_out(icache_out), .icache_out_valid(icache_out_valid)
	);

endmodule

// File: tb_memory_model.sv
`timescale 1ns/10ps

module tb_memory_model (
	input  logic                                     clk,
	input  logic                                     reset_n,
	input  logic [cache_geometry_pkg::ADDR_BITS-1:0] mem_addr,
	input  logic [cache_geometry_pkg::DATA_BITS-1:0] mem_in,
	input  logic                                     mem_wrreq,
	input  logic                                     mem_rdreq,
	output logic [cache_geometry_pkg::DATA_BITS-1:0] mem_out,
	output logic                                     mem_out_valid,
	input  logic [cache_geometry_pkg::ADDR_BITS-1:0] peek_addr,
	output logic [cache_geometry_pkg::DATA_BITS-1:0] peek_data
);

	localparam logic [31:0] RANDOM_SEED = 32'hed37_5b17;
	localparam logic [cache_geometry_pkg::DATA_BITS-1:0] FILL_MASK = 32'h5a5a_0000;

	// only written words are stored, every other word follows the fill pattern
	logic [cache_geometry_pkg::DATA_BITS-1:0] words [logic [cache_geometry_pkg::ADDR_BITS-1:0]];
	logic [cache_geometry_pkg::ADDR_BITS-1:0] rd_addr;
	int wait_left;
	bit busy;
	int unsigned seed_ret;

	function automatic logic [cache_geometry_pkg::DATA_BITS-1:0] word_at(
		input logic [cache_geometry_pkg::ADDR_BITS-1:0] addr);
		if (words.exists(addr))
			return words[addr];
		else
			return addr ^ FILL_MASK;
	endfunction

	// one process seeds the generator and then serves every transfer
	initial begin
		seed_ret = $urandom(RANDOM_SEED);
		busy = 1'b0;
		wait_left = 0;
		rd_addr = '0;
		mem_out <= '0;
		mem_out_valid <= 1'b0;
		peek_data <= '0;
		forever begin
			@(posedge clk or negedge reset_n);
			if (!reset_n) begin
				busy = 1'b0;
				mem_out_valid <= 1'b0;
			end else begin
				mem_out_valid <= 1'b0;
				peek_data <= word_at(peek_addr);
				if (mem_wrreq)
					words[mem_addr] = mem_in;
				if (busy) begin
					wait_left = wait_left - 1;
					if (wait_left == 0) begin
						mem_out <= word_at(rd_addr);
						mem_out_valid <= 1'b1;
						busy = 1'b0;
					end
				end
				// read data comes back 1 to 4 cycles after the request
				if (mem_rdreq) begin
					rd_addr = mem_addr;
					busy = 1'b1;
					wait_left = 1 + int'($urandom % 4);
				end
			end
		end
	end

endmodule

// File: tb_hybrid_cache.sv
`timescale 1ns/10ps

module tb_hybrid_cache;

	localparam int AW = cache_geometry_pkg::ADDR_BITS;
	localparam int DW = cache_geometry_pkg::DATA_BITS;
	localparam int SW = cache_ctrl_pkg::SRC_BITS;
	localparam logic [SW-1:0] DRD = cache_ctrl_pkg::SRC_DCACHE_RD;
	localparam logic [SW-1:0] DWR = cache_ctrl_pkg::SRC_DCACHE_WR;
	localparam logic [SW-1:0] IRD = cache_ctrl_pkg::SRC_ICACHE_RD;
	localparam int TIMEOUT_CYCLES = 200;
	localparam int BURST_LEN = 8;
	localparam logic [DW-1:0] WORD_A = 32'h1234_abcd;
	localparam logic [DW-1:0] WORD_B = 32'h0bad_f00d;

	logic clk;
	logic reset_n;
	logic [AW-1:0] dcache_rdaddr;
	logic dcache_rdreq;
	logic dcache_rd_ready;
	logic [DW-1:0] dcache_out;
	logic dcache_out_valid;
	logic [AW-1:0] dcache_wraddr;
	logic [DW-1:0] dcache_in;
	logic dcache_wrreq;
	logic dcache_wr_ready;
	logic [AW-1:0] icache_rdaddr;
	logic icache_rdreq;
	logic icache_rd_ready;
	logic [DW-1:0] icache_out;
	logic icache_out_valid;
	logic [AW-1:0] mem_addr;
	logic [DW-1:0] mem_in;
	logic [DW-1:0] mem_out;
	logic mem_out_valid;
	logic mem_wrreq;
	logic mem_rdreq;
	logic [AW-1:0] peek_addr;
	logic [DW-1:0] peek_data;

	string row_name[$];
	logic [SW-1:0] row_op[$];
	logic [AW-1:0] row_addr[$];
	logic [DW-1:0] row_wdata[$];
	logic [DW-1:0] row_expect[$];
	logic [AW-1:0] burst_addr [BURST_LEN];
	logic [DW-1:0] written [logic [AW-1:0]];
	logic [DW-1:0] dcache_seen[$];
	logic [DW-1:0] icache_seen[$];
	int tests;
	int errors;
	bit timed_out;

	hybrid_cache dut_i (.*);
	tb_memory_model mem_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// outputs change at the rising edge, so the falling edge sees them settled
	always @(negedge clk) begin
		if (dcache_out_valid === 1'b1)
			dcache_seen.push_back(dcache_out);
		if (icache_out_valid === 1'b1)
			icache_seen.push_back(icache_out);
	end

	function automatic logic [DW-1:0] rule_word(input logic [AW-1:0] addr);
		return addr ^ 32'h5a5a_0000;
	endfunction

	function automatic logic port_ready(input logic [SW-1:0] op);
		if (op == DWR)
			return dcache_wr_ready;
		if (op == IRD)
			return icache_rd_ready;
		return dcache_rd_ready;
	endfunction

	function automatic int pending(input logic [SW-1:0] op);
		if (op == IRD)
			return icache_seen.size();
		return dcache_seen.size();
	endfunction

	task automatic check_dcache(input string name, input logic [DW-1:0] expected,
		input logic [DW-1:0] actual);
		tests++;
		if (actual !== expected) begin
			errors++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end else begin
			$display("ok %s: dcache_out %h", name, actual);
		end
	endtask

	task automatic check_icache(input string name, input logic [DW-1:0] expected,
		input logic [DW-1:0] actual);
		tests++;
		if (actual !== expected) begin
			errors++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end else begin
			$display("ok %s: icache_out %h", name, actual);
		end
	endtask

	task automatic check_memory(input string name, input logic [AW-1:0] addr,
		input logic [DW-1:0] expected);
		@(negedge clk);
		peek_addr = addr;
		@(posedge clk);
		@(negedge clk);
		tests++;
		if (peek_data !== expected) begin
			errors++;
			$display("** Error %s: expected %h, actual %h", name, expected, peek_data);
		end else begin
			$display("ok %s: memory word %h holds %h", name, addr, peek_data);
		end
	endtask

	task automatic note_timeout(input string name, input string what);
		tests++;
		errors++;
		timed_out = 1'b1;
		$display("%s: timed out, %s", name, what);
	endtask

	// starts at a falling edge and returns at the falling edge after acceptance
	task automatic issue(input logic [SW-1:0] op, input logic [AW-1:0] addr,
		input logic [DW-1:0] wdata, output bit ok);
		int waited;
		waited = 0;
		while (!port_ready(op) && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		ok = port_ready(op);
		if (!ok)
			return;
		dcache_rdaddr = addr;
		dcache_wraddr = addr;
		icache_rdaddr = addr;
		dcache_in = wdata;
		dcache_rdreq = (op == DRD);
		dcache_wrreq = (op == DWR);
		icache_rdreq = (op == IRD);
		@(negedge clk);
		dcache_rdreq = 1'b0;
		dcache_wrreq = 1'b0;
		icache_rdreq = 1'b0;
	endtask

	task automatic wait_response(input logic [SW-1:0] op, output logic [DW-1:0] word,
		output bit ok);
		int waited;
		waited = 0;
		while (pending(op) == 0 && waited < TIMEOUT_CYCLES) begin
			@(posedge clk);
			waited++;
		end
		ok = (pending(op) != 0);
		word = '0;
		if (ok && op == IRD)
			word = icache_seen.pop_front();
		else if (ok)
			word = dcache_seen.pop_front();
	endtask

	task automatic run_row(input int i);
		logic [DW-1:0] word;
		bit ok;
		@(negedge clk);
		issue(row_op[i], row_addr[i], row_wdata[i], ok);
		if (!ok) begin
			note_timeout(row_name[i], "the request port never became ready");
			return;
		end
		if (row_op[i] == DWR) begin
			written[row_addr[i]] = row_wdata[i];
			tests++;
			$display("ok %s: write accepted", row_name[i]);
			return;
		end
		wait_response(row_op[i], word, ok);
		if (!ok)
			note_timeout(row_name[i], "no read response arrived");
		else if (row_op[i] == IRD)
			check_icache(row_name[i], row_expect[i], word);
		else
			check_dcache(row_name[i], row_expect[i], word);
		if (ok && row_op[i] == IRD && dcache_seen.size() != 0) begin
			errors++;
			$display("%s: dcache_out_valid pulsed for an instruction read", row_name[i]);
		end
	endtask

	// all reads go out first, so the queue fills and ready drops
	task automatic run_burst();
		logic [DW-1:0] word;
		logic [DW-1:0] expected;
		bit ok;
		@(negedge clk);
		for (int i = 0; i < BURST_LEN; i++) begin
			issue(DRD, burst_addr[i], '0, ok);
			if (!ok) begin
				note_timeout("burst", "dcache_rd_ready stayed low");
				return;
			end
		end
		for (int i = 0; i < BURST_LEN; i++) begin
			wait_response(DRD, word, ok);
			if (!ok) begin
				note_timeout("burst", "a read of the burst got no response");
				return;
			end
			if (written.exists(burst_addr[i]))
				expected = written[burst_addr[i]];
			else
				expected = rule_word(burst_addr[i]);
			check_dcache($sformatf("burst read %0d of %h", i, burst_addr[i]), expected, word);
		end
	endtask

	task automatic add_row(input string name, input logic [SW-1:0] op,
		input logic [AW-1:0] addr, input logic [DW-1:0] wdata, input logic [DW-1:0] expected);
		row_name.push_back(name);
		row_op.push_back(op);
		row_addr.push_back(addr);
		row_wdata.push_back(wdata);
		row_expect.push_back(expected);
	endtask

	task automatic load_table();
		add_row("cold read 100", DRD, 32'h100, '0, rule_word(32'h100));
		add_row("same region 101", DRD, 32'h101, '0, rule_word(32'h101));
		add_row("write 200", DWR, 32'h200, WORD_A, '0);
		add_row("read back 200", DRD, 32'h200, '0, WORD_A);
		add_row("neighbour 203", DRD, 32'h203, '0, rule_word(32'h203));
		add_row("icache read 200", IRD, 32'h200, '0, WORD_A);
		// the new dirty line keeps the lowest count and is pushed out by region 500
		add_row("write 300", DWR, 32'h300, WORD_B, '0);
		add_row("touch 100", DRD, 32'h100, '0, rule_word(32'h100));
		add_row("touch 200", DRD, 32'h200, '0, WORD_A);
		add_row("touch 400", DRD, 32'h400, '0, rule_word(32'h400));
		add_row("touch 500", DRD, 32'h500, '0, rule_word(32'h500));
		add_row("touch 600", DRD, 32'h600, '0, rule_word(32'h600));
		add_row("reread 300", DRD, 32'h300, '0, WORD_B);
		burst_addr = '{32'h300, 32'h301, 32'h700, 32'h702, 32'h200, 32'h100, 32'h800, 32'h303};
	endtask

	initial begin
		reset_n = 1'b0;
		dcache_rdaddr = '0;
		dcache_rdreq = 1'b0;
		dcache_wraddr = '0;
		dcache_in = '0;
		dcache_wrreq = 1'b0;
		icache_rdaddr = '0;
		icache_rdreq = 1'b0;
		peek_addr = '0;
		tests = 0;
		errors = 0;
		timed_out = 1'b0;
		load_table();
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
		for (int i = 0; i < row_name.size() && !timed_out; i++)
			run_row(i);
		if (!timed_out)
			run_burst();
		if (!timed_out) begin
			check_memory("write-back of 300", 32'h300, WORD_B);
			check_memory("write-back of 301", 32'h301, rule_word(32'h301));
			if (dcache_seen.size() != 0 || icache_seen.size() != 0) begin
				errors++;
				$display("responses arrived that no request asked for");
			end
		end
		$display("tests run %0d, failures %0d", tests, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: verilog.f
cache_geometry_pkg.sv
cache_ctrl_pkg.sv
request_queue.sv
request_intake.sv
cache_lines.sv
miss_controller.sv
response_router.sv
hybrid_cache.sv
tb_memory_model.sv
tb_hybrid_cache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the cache testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_hybrid_cache
./obj_dir/Vtb_hybrid_cache | tee sim.log

if ! grep -qx "TEST PASS" sim.log; then
	echo "simulation did not pass"
	exit 1
fi
